/* hw/axil_pkg.sv */
`default_nettype none

package axil_pkg;

   // bus widths
   localparam int DATA_W    = 32;
   localparam int ADDR_W    = 32;
   localparam int REG_IDX_W = 3;

   // register byte offsets, everything else is unmapped
   localparam logic [ADDR_W-1:0] OFS_CTRL   = 32'h0000_0000;
   localparam logic [ADDR_W-1:0] OFS_OPA    = 32'h0000_0004;
   localparam logic [ADDR_W-1:0] OFS_OPB    = 32'h0000_0008;
   localparam logic [ADDR_W-1:0] OFS_RESULT = 32'h0000_000C;
   localparam logic [ADDR_W-1:0] OFS_ID     = 32'h0000_0010;

   // register indices
   localparam logic [REG_IDX_W-1:0] IDX_CTRL   = 3'd0;
   localparam logic [REG_IDX_W-1:0] IDX_OPA    = 3'd1;
   localparam logic [REG_IDX_W-1:0] IDX_OPB    = 3'd2;
   localparam logic [REG_IDX_W-1:0] IDX_RESULT = 3'd3;
   localparam logic [REG_IDX_W-1:0] IDX_ID     = 3'd4;

   // operation select, ctrl bits 1:0
   localparam logic [1:0] OP_ADD = 2'd0;
   localparam logic [1:0] OP_SUB = 2'd1;
   localparam logic [1:0] OP_AND = 2'd2;
   localparam logic [1:0] OP_XOR = 2'd3;

   // fixed identification word
   localparam logic [DATA_W-1:0] ID_VALUE = 32'hA71C_0001;

   // AXI response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // channel FSM states
   localparam logic [2:0] ST_IDLE     = 3'd0;
   localparam logic [2:0] ST_READ     = 3'd1;
   localparam logic [2:0] ST_WRITE    = 3'd2;
   localparam logic [2:0] ST_RESP     = 3'd3;
   localparam logic [2:0] ST_ACK_WAIT = 3'd4;

endpackage

`default_nettype wire

/* hw/axil_channel_fsm.sv */
`default_nettype none

module axil_channel_fsm
   import axil_pkg::*;
(
   input  wire                  S_AXI_ACLK,
   input  wire                  S_AXI_ARESETN,
   // read address / data channels
   input  wire  [ADDR_W-1:0]    araddr_i,
   input  wire                  arvalid_i,
   output logic                 arready_o,
   output logic [DATA_W-1:0]    rdata_o,
   output logic [1:0]           rresp_o,
   output logic                 rvalid_o,
   input  wire                  rready_i,
   // write address / data / response channels
   input  wire  [ADDR_W-1:0]    awaddr_i,
   input  wire                  awvalid_i,
   output logic                 awready_o,
   input  wire  [DATA_W-1:0]    wdata_i,
   input  wire                  wvalid_i,
   output logic                 wready_o,
   output logic [1:0]           bresp_o,
   output logic                 bvalid_o,
   input  wire                  bready_i,
   // request side of req/ack
   output logic                 req_o,
   output logic [ADDR_W-1:0]    req_addr_o,
   output logic                 req_we_o,
   output logic [DATA_W-1:0]    req_wdata_o,
   input  wire                  req_legal_i,
   input  wire                  ack_i,
   input  wire  [DATA_W-1:0]    ack_rdata_i
);

   logic [2:0]        state_q;
   logic              req_q;
   logic              rvalid_q;
   logic              bvalid_q;
   logic [ADDR_W-1:0] addr_q;
   logic              we_q;
   logic [DATA_W-1:0] wdata_q;
   logic [DATA_W-1:0] rdata_q;
   logic [1:0]        rresp_q;
   logic [1:0]        bresp_q;
   logic              rd_done;
   logic              wr_done;
   logic              resp_done;

   // access handed over and acknowledged
   assign rd_done   = (state_q == ST_READ) && ack_i;
   assign wr_done   = (state_q == ST_WRITE) && ack_i;
   assign resp_done = (rvalid_q && rready_i) || (bvalid_q && bready_i);

   always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
      if (!S_AXI_ARESETN) begin
         state_q  <= ST_IDLE;
         req_q    <= 1'b0;
         rvalid_q <= 1'b0;
         bvalid_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               // read has priority over a simultaneous write
               if (arvalid_i) begin
                  state_q <= ST_READ;
                  req_q   <= 1'b1;
               end else if (awvalid_i && wvalid_i) begin
                  state_q <= ST_WRITE;
                  req_q   <= 1'b1;
               end
            end
            ST_READ: begin
               if (ack_i) begin
                  req_q    <= 1'b0;
                  rvalid_q <= 1'b1;
                  state_q  <= ST_RESP;
               end
            end
            ST_WRITE: begin
               if (ack_i) begin
                  req_q    <= 1'b0;
                  bvalid_q <= 1'b1;
                  state_q  <= ST_RESP;
               end
            end
            ST_RESP: begin
               // hold the response until the master takes it
               if (resp_done) begin
                  rvalid_q <= 1'b0;
                  bvalid_q <= 1'b0;
                  state_q  <= ack_i ? ST_ACK_WAIT : ST_IDLE;
               end
            end
            ST_ACK_WAIT: begin
               // finish the four-phase cycle before the next req
               if (!ack_i) begin
                  state_q <= ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // address and data latched on the way out of idle
   always_ff @(posedge S_AXI_ACLK) begin
      if (state_q == ST_IDLE) begin
         if (arvalid_i) begin
            addr_q <= araddr_i;
            we_q   <= 1'b0;
         end else if (awvalid_i && wvalid_i) begin
            addr_q  <= awaddr_i;
            we_q    <= 1'b1;
            wdata_q <= wdata_i;
         end
      end
      if (rd_done) begin
         rdata_q <= ack_rdata_i;
         rresp_q <= req_legal_i ? RESP_OKAY : RESP_SLVERR;
      end
      if (wr_done) begin
         bresp_q <= req_legal_i ? RESP_OKAY : RESP_SLVERR;
      end
   end

   assign arready_o   = rd_done;
   assign awready_o   = wr_done;
   assign wready_o    = wr_done;
   assign rdata_o     = rdata_q;
   assign rresp_o     = rresp_q;
   assign rvalid_o    = rvalid_q;
   assign bresp_o     = bresp_q;
   assign bvalid_o    = bvalid_q;
   assign req_o       = req_q;
   assign req_addr_o  = addr_q;
   assign req_we_o    = we_q;
   assign req_wdata_o = wdata_q;

   // one access at a time, so never both responses pending
   a_one_resp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      !(rvalid_q && bvalid_q));

   // ack still high when req drops, the unit waits for req low
   a_req_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      $fell(req_q) |-> ack_i);

endmodule

`default_nettype wire

/* hw/reg_addr_decode.sv */
`default_nettype none

module reg_addr_decode
   import axil_pkg::*;
(
   input  wire  [ADDR_W-1:0]    addr_i,
   input  wire                  we_i,
   output logic [REG_IDX_W-1:0] idx_o,
   output logic                 legal_o
);

   logic              aligned;
   logic [ADDR_W-1:0] word_addr;
   logic              mapped;
   logic              read_only;

   assign aligned   = (addr_i[1:0] == 2'b00);
   assign word_addr = {addr_i[ADDR_W-1:2], 2'b00};

   always_comb begin
      idx_o     = IDX_CTRL;
      mapped    = 1'b1;
      read_only = 1'b0;
      case (word_addr)
         OFS_CTRL: begin
            idx_o = IDX_CTRL;
         end
         OFS_OPA: begin
            idx_o = IDX_OPA;
         end
         OFS_OPB: begin
            idx_o = IDX_OPB;
         end
         OFS_RESULT: begin
            idx_o     = IDX_RESULT;
            read_only = 1'b1;
         end
         OFS_ID: begin
            idx_o     = IDX_ID;
            read_only = 1'b1;
         end
         default: begin
            // unmapped, index is don't-care once legal is low
            mapped = 1'b0;
         end
      endcase
   end

   // writes to result or id are rejected
   assign legal_o = aligned && mapped && !(we_i && read_only);

endmodule

`default_nettype wire

/* hw/arith_reg_unit.sv */
`default_nettype none

module arith_reg_unit
   import axil_pkg::*;
(
   input  wire                  S_AXI_ACLK,
   input  wire                  S_AXI_ARESETN,
   input  wire                  req_i,
   input  wire                  we_i,
   input  wire  [REG_IDX_W-1:0] idx_i,
   input  wire                  legal_i,
   input  wire  [DATA_W-1:0]    wdata_i,
   output logic                 ack_o,
   output logic [DATA_W-1:0]    rdata_o
);

   logic              ack_q;
   logic [DATA_W-1:0] rdata_q;
   logic [DATA_W-1:0] ctrl_q;
   logic [DATA_W-1:0] opa_q;
   logic [DATA_W-1:0] opb_q;
   logic [DATA_W-1:0] result_q;
   logic              recalc_q;
   logic              accept;
   logic              wr_en;
   logic [DATA_W-1:0] sel_data;
   logic [DATA_W-1:0] result_d;

   // new request seen, ack rises on this edge
   assign accept = req_i && !ack_q;
   assign wr_en  = accept && legal_i && we_i;

   // ack simply follows req one cycle later
   always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
      if (!S_AXI_ARESETN) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req_i;
      end
   end

   // register bank, only legal writes reach here
   always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
      if (!S_AXI_ARESETN) begin
         ctrl_q   <= '0;
         opa_q    <= '0;
         opb_q    <= '0;
         result_q <= '0;
         recalc_q <= 1'b0;
      end else begin
         recalc_q <= wr_en;
         if (wr_en) begin
            case (idx_i)
               IDX_CTRL: ctrl_q <= wdata_i;
               IDX_OPA:  opa_q  <= wdata_i;
               IDX_OPB:  opb_q  <= wdata_i;
               default:  ;
            endcase
         end
         // result follows one cycle after the write that changed its inputs
         if (recalc_q) begin
            result_q <= result_d;
         end
      end
   end

   always_comb begin
      case (ctrl_q[1:0])
         OP_ADD:  result_d = opa_q + opb_q;
         OP_SUB:  result_d = opa_q - opb_q;
         OP_AND:  result_d = opa_q & opb_q;
         OP_XOR:  result_d = opa_q ^ opb_q;
         default: result_d = '0;
      endcase
   end

   // read mux, zero for anything illegal
   always_comb begin
      sel_data = '0;
      if (legal_i) begin
         case (idx_i)
            IDX_CTRL:   sel_data = ctrl_q;
            IDX_OPA:    sel_data = opa_q;
            IDX_OPB:    sel_data = opb_q;
            IDX_RESULT: sel_data = result_q;
            IDX_ID:     sel_data = ID_VALUE;
            default:    sel_data = '0;
         endcase
      end
   end

   always_ff @(posedge S_AXI_ACLK) begin
      if (accept) begin
         rdata_q <= sel_data;
      end
   end

   assign ack_o   = ack_q;
   assign rdata_o = rdata_q;

   // ack must answer a live request
   a_ack_on_req: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
      $rose(ack_q) |-> req_i);

endmodule

`default_nettype wire

/* hw/axil_arith_top.sv */
`default_nettype none

module axil_arith_top
   import axil_pkg::*;
(
   input  wire                  S_AXI_ACLK,
   input  wire                  S_AXI_ARESETN,
   input  wire  [ADDR_W-1:0]    S_AXI_ARADDR_i,
   input  wire                  S_AXI_ARVALID_i,
   output logic                 S_AXI_ARREADY_o,
   output logic [DATA_W-1:0]    S_AXI_RDATA_o,
   output logic [1:0]           S_AXI_RRESP_o,
   output logic                 S_AXI_RVALID_o,
   input  wire                  S_AXI_RREADY_i,
   input  wire  [ADDR_W-1:0]    S_AXI_AWADDR_i,
   input  wire                  S_AXI_AWVALID_i,
   output logic                 S_AXI_AWREADY_o,
   input  wire  [DATA_W-1:0]    S_AXI_WDATA_i,
   input  wire                  S_AXI_WVALID_i,
   output logic                 S_AXI_WREADY_o,
   output logic [1:0]           S_AXI_BRESP_o,
   output logic                 S_AXI_BVALID_o,
   input  wire                  S_AXI_BREADY_i
);

   // req/ack between the front end and the register unit
   logic                 req;
   logic [ADDR_W-1:0]    req_addr;
   logic                 req_we;
   logic [DATA_W-1:0]    req_wdata;
   logic [REG_IDX_W-1:0] req_idx;
   logic                 req_legal;
   logic                 ack;
   logic [DATA_W-1:0]    ack_rdata;

   axil_channel_fsm u_fsm (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .araddr_i      (S_AXI_ARADDR_i),
      .arvalid_i     (S_AXI_ARVALID_i),
      .arready_o     (S_AXI_ARREADY_o),
      .rdata_o       (S_AXI_RDATA_o),
      .rresp_o       (S_AXI_RRESP_o),
      .rvalid_o      (S_AXI_RVALID_o),
      .rready_i      (S_AXI_RREADY_i),
      .awaddr_i      (S_AXI_AWADDR_i),
      .awvalid_i     (S_AXI_AWVALID_i),
      .awready_o     (S_AXI_AWREADY_o),
      .wdata_i       (S_AXI_WDATA_i),
      .wvalid_i      (S_AXI_WVALID_i),
      .wready_o      (S_AXI_WREADY_o),
      .bresp_o       (S_AXI_BRESP_o),
      .bvalid_o      (S_AXI_BVALID_o),
      .bready_i      (S_AXI_BREADY_i),
      .req_o         (req),
      .req_addr_o    (req_addr),
      .req_we_o      (req_we),
      .req_wdata_o   (req_wdata),
      .req_legal_i   (req_legal),
      .ack_i         (ack),
      .ack_rdata_i   (ack_rdata)
   );

   reg_addr_decode u_decode (
      .addr_i  (req_addr),
      .we_i    (req_we),
      .idx_o   (req_idx),
      .legal_o (req_legal)
   );

   arith_reg_unit u_regs (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .req_i         (req),
      .we_i          (req_we),
      .idx_i         (req_idx),
      .legal_i       (req_legal),
      .wdata_i       (req_wdata),
      .ack_o         (ack),
      .rdata_o       (ack_rdata)
   );

endmodule

`default_nettype wire

/* tb/tb_axil_arith.sv */
`default_nettype none

module tb_axil_arith;

   logic        S_AXI_ACLK;
   logic        S_AXI_ARESETN;
   logic [31:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;
   logic [31:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;

   // one entry per access in the test file
   logic [7:0]  t_op[$];
   logic [31:0] t_addr[$];
   logic [31:0] t_wdata[$];
   logic [31:0] t_rdata[$];
   logic [1:0]  t_resp[$];
   string       t_name[$];

   int   cycle_cnt   = 0;
   int   cycle_limit = 0;
   int   rd_seen     = 0;
   int   wr_seen     = 0;
   int   exp_rd      = 0;
   int   exp_wr      = 0;
   logic r_pend      = 1'b0;
   logic b_pend      = 1'b0;

   axil_arith_top DUT (
      .S_AXI_ACLK      (S_AXI_ACLK),
      .S_AXI_ARESETN   (S_AXI_ARESETN),
      .S_AXI_ARADDR_i  (araddr),
      .S_AXI_ARVALID_i (arvalid),
      .S_AXI_ARREADY_o (arready),
      .S_AXI_RDATA_o   (rdata),
      .S_AXI_RRESP_o   (rresp),
      .S_AXI_RVALID_o  (rvalid),
      .S_AXI_RREADY_i  (rready),
      .S_AXI_AWADDR_i  (awaddr),
      .S_AXI_AWVALID_i (awvalid),
      .S_AXI_AWREADY_o (awready),
      .S_AXI_WDATA_i   (wdata),
      .S_AXI_WVALID_i  (wvalid),
      .S_AXI_WREADY_o  (wready),
      .S_AXI_BRESP_o   (bresp),
      .S_AXI_BVALID_o  (bvalid),
      .S_AXI_BREADY_i  (bready)
   );

   initial begin
      S_AXI_ACLK = 1'b0;
      forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
   end

   task automatic fail_run(input string why);
      $display("ERROR: %s", why);
      $display("Simulation failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         $display("Simulation failed");
         $fatal(1, "mismatch");
      end
   endtask

   // mid-cycle sampling, inputs and outputs both settled
   always @(negedge S_AXI_ACLK) begin
      cycle_cnt++;
      // a beat is new unless the last sample left it waiting for ready
      if (rvalid && !r_pend) rd_seen++;
      if (bvalid && !b_pend) wr_seen++;
      r_pend = rvalid && !rready;
      b_pend = bvalid && !bready;
      if (rvalid && bvalid) begin
         fail_run("read and write responses were valid in the same cycle");
      end
      if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
         fail_run($sformatf("timeout, the tests did not finish in %0d cycles", cycle_limit));
      end
   end

   task automatic tick();
      @(posedge S_AXI_ACLK);
      #1;
   endtask

   // ready held back a few cycles, response must not move meanwhile
   task automatic take_resp(input string name, input bit is_wr,
                            input logic [31:0] exp_data, input logic [1:0] exp_resp);
      logic [31:0] held_data;
      logic [1:0]  held_resp;
      int          stall;
      stall = int'($urandom % 6);
      while (!(is_wr ? bvalid : rvalid)) begin
         tick();
      end
      held_resp = is_wr ? bresp : rresp;
      if (!is_wr) begin
         held_data = rdata;
         check_value({name, " data"}, exp_data, held_data);
      end
      check_value({name, " resp"}, 32'(exp_resp), 32'(held_resp));
      repeat (stall) begin
         tick();
         check_value({name, " valid held"}, 32'd1, 32'(is_wr ? bvalid : rvalid));
         if (!is_wr) begin
            check_value({name, " data stable"}, held_data, rdata);
         end
         check_value({name, " resp stable"}, 32'(held_resp), 32'(is_wr ? bresp : rresp));
      end
      rready = !is_wr;
      bready = is_wr;
      tick();
      rready = 1'b0;
      bready = 1'b0;
      check_value({name, " valid cleared"}, 32'd0, 32'(is_wr ? bvalid : rvalid));
   endtask

   task automatic do_read(input string name, input logic [31:0] addr,
                          input logic [31:0] exp_data, input logic [1:0] exp_resp);
      araddr  = addr;
      arvalid = 1'b1;
      while (!arready) begin
         tick();
      end
      tick();
      arvalid = 1'b0;
      take_resp(name, 1'b0, exp_data, exp_resp);
   endtask

   task automatic do_write(input string name, input logic [31:0] addr,
                           input logic [31:0] data, input logic [1:0] exp_resp);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      while (!awready) begin
         tick();
      end
      check_value({name, " wready"}, 32'd1, 32'(wready));
      tick();
      awvalid = 1'b0;
      wvalid  = 1'b0;
      take_resp(name, 1'b1, 32'h0, exp_resp);
   endtask

   // read and write raised together, the read has to go first
   task automatic do_both(input string name, input logic [31:0] addr, input logic [31:0] data,
                          input logic [31:0] exp_data, input logic [1:0] exp_resp);
      araddr  = addr;
      awaddr  = addr;
      wdata   = data;
      arvalid = 1'b1;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      while (!arready) begin
         check_value({name, " write ahead of read"}, 32'd0, 32'(awready));
         tick();
      end
      tick();
      arvalid = 1'b0;
      take_resp(name, 1'b0, exp_data, exp_resp);
      do_write(name, addr, data, exp_resp);
   endtask

   task automatic load_tests();
      integer           fd;
      int               n;
      logic [8*160-1:0] line;
      logic [7:0]       op;
      logic [31:0]      addr;
      logic [31:0]      wd;
      logic [31:0]      rd;
      logic [1:0]       resp;
      logic [8*32-1:0]  name;
      fd = $fopen("tb/axil_tests.txt", "r");
      if (fd == 0) begin
         fail_run("cannot open tb/axil_tests.txt");
      end
      while (!$feof(fd)) begin
         line = '0;
         void'($fgets(line, fd));
         n = $sscanf(line, "%s %h %h %h %h %s", op, addr, wd, rd, resp, name);
         // blank lines and comment lines carry no access
         if (n > 0 && op != "#") begin
            if (n != 6) begin
               fail_run("malformed line in tb/axil_tests.txt");
            end
            t_op.push_back(op);
            t_addr.push_back(addr);
            t_wdata.push_back(wd);
            t_rdata.push_back(rd);
            t_resp.push_back(resp);
            t_name.push_back($sformatf("%0s", name));
         end
      end
      $fclose(fd);
   endtask

   initial begin
      S_AXI_ARESETN = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      void'($urandom(32'h57c1_add2));
      load_tests();
      cycle_limit = t_op.size() * 64 + 20;
      repeat (5) @(posedge S_AXI_ACLK);
      #1;
      S_AXI_ARESETN = 1'b1;
      foreach (t_op[i]) begin
         case (t_op[i])
            "R": begin
               exp_rd++;
               do_read(t_name[i], t_addr[i], t_rdata[i], t_resp[i]);
            end
            "W": begin
               exp_wr++;
               do_write(t_name[i], t_addr[i], t_wdata[i], t_resp[i]);
            end
            "S": begin
               exp_rd++;
               exp_wr++;
               do_both(t_name[i], t_addr[i], t_wdata[i], t_rdata[i], t_resp[i]);
            end
            default: fail_run($sformatf("unknown operation in test %s", t_name[i]));
         endcase
      end
      // each access answered exactly once
      check_value("read responses", exp_rd, rd_seen);
      check_value("write responses", exp_wr, wr_seen);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/axil_tests.txt */
# op addr wdata exp_rdata exp_resp name, all numbers in hex
# op: R read, W write, S read and write of the same address in one cycle
R 00000000 00000000 00000000 0 rst_ctrl
R 00000004 00000000 00000000 0 rst_opa
R 00000008 00000000 00000000 0 rst_opb
R 0000000C 00000000 00000000 0 rst_result
R 00000010 00000000 A71C0001 0 rst_id
W 00000004 FFFFFFF0 00000000 0 wr_opa
W 00000008 00000020 00000000 0 wr_opb
R 0000000C 00000000 00000010 0 add_wrap
W 00000000 00000001 00000000 0 wr_ctrl_sub
R 00000000 00000000 00000001 0 rd_ctrl
R 0000000C 00000000 FFFFFFD0 0 sub_result
W 00000004 00000005 00000000 0 wr_opa_small
R 0000000C 00000000 FFFFFFE5 0 sub_wrap
W 00000000 00000002 00000000 0 wr_ctrl_and
W 00000008 0000000C 00000000 0 wr_opb_c
R 0000000C 00000000 00000004 0 and_result
W 00000000 00000003 00000000 0 wr_ctrl_xor
R 0000000C 00000000 00000009 0 xor_result
R 00000020 00000000 00000000 2 rd_unmapped
R 00000006 00000000 00000000 2 rd_unaligned
W 00000005 FFFFFFFF 00000000 2 wr_unaligned
W 0000000C 12345678 00000000 2 wr_result_ro
W 00000010 12345678 00000000 2 wr_id_ro
W 00000040 12345678 00000000 2 wr_unmapped
R 00000000 00000000 00000003 0 chk_ctrl
R 00000004 00000000 00000005 0 chk_opa
R 00000008 00000000 0000000C 0 chk_opb
R 0000000C 00000000 00000009 0 chk_result
R 00000010 00000000 A71C0001 0 chk_id
S 00000004 0000AAAA 00000005 0 simul_rd_wr
R 00000004 00000000 0000AAAA 0 after_simul
R 0000000C 00000000 0000AAA6 0 after_simul_res

/* src.f */
hw/axil_pkg.sv
hw/axil_channel_fsm.sv
hw/reg_addr_decode.sv
hw/arith_reg_unit.sv
hw/axil_arith_top.sv
tb/tb_axil_arith.sv

/* Makefile */
TOP := tb_axil_arith
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Simulation completed successfully$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
